// File: bench/tb_mac_rx_tasks.svh
`ifndef TB_MAC_RX_TASKS_SVH
`define TB_MAC_RX_TASKS_SVH

// --------------------
// frame building
// --------------------

task automatic make_payload(input int n);
	pl_q.delete();
	repeat (n) begin
		pl_q.push_back(8'($random(seed)));
	end
endtask

// bit-serial crc-32 over pl_q, lsb of each byte first
function automatic logic [31:0] calc_fcs();
	logic [31:0] crc;
	logic        fb;
	crc = 32'hffff_ffff;
	foreach (pl_q[i]) begin
		for (int b = 0; b < 8; b++) begin
			fb  = crc[0] ^ pl_q[i][b];
			crc = crc >> 1;
			if (fb) begin
				crc = crc ^ CRC_POLY;
			end
		end
	end
	return ~crc;
endfunction

// fcs goes out low byte first, flip corrupts chosen bits
task automatic append_fcs(input logic [31:0] flip);
	logic [31:0] fcs;
	fcs = calc_fcs() ^ flip;
	for (int i = 0; i < 4; i++) begin
		pl_q.push_back(fcs[8*i +: 8]);
	end
endtask

task automatic expect_frame();
	exp_byte_t e;
	foreach (pl_q[i]) begin
		e.sop  = (i == 0);
		e.eop  = (i == pl_q.size() - 1);
		e.data = pl_q[i];
		exp_q.push_back(e);
	end
endtask

// 7x 0x55, sfd, then the frame
task automatic load_frame();
	tx_q.delete();
	repeat (7) begin
		tx_q.push_back(8'h55);
	end
	tx_q.push_back(8'hd5);
	foreach (pl_q[i]) begin
		tx_q.push_back(pl_q[i]);
	end
endtask

// --------------------
// rmii drive
// --------------------

task automatic drive_dibit(input logic [1:0] d);
	@(posedge i_clk);
	#1;
	i_rmii_rxvld  = 1'b1;
	i_rmii_rxdata = d;
endtask

task automatic drive_idle(input int n);
	repeat (n) begin
		@(posedge i_clk);
		#1;
		i_rmii_rxvld  = 1'b0;
		i_rmii_rxdata = 2'b00;
	end
endtask

// low pair first, optional stray dibits, then the gap
task automatic drive_burst(input int extra_dibits);
	foreach (tx_q[i]) begin
		for (int k = 0; k < 4; k++) begin
			drive_dibit(tx_q[i][2*k +: 2]);
		end
	end
	repeat (extra_dibits) begin
		drive_dibit(2'($random(seed)));
	end
	drive_idle(IFG_CYCLES);
endtask

// --------------------
// output checks
// --------------------

task automatic check_rx_byte();
	exp_byte_t e;
	assert (exp_q.size() != 0)
		else report_fail("output byte seen while no frame was expected");
	e = exp_q.pop_front();
	assert (o_rx_dat == e.data)
		else report_fail($sformatf("Mismatch o_rx_dat: got %h expected %h", o_rx_dat, e.data));
	assert (o_rx_sop == e.sop)
		else report_fail($sformatf("Mismatch o_rx_sop: got %h expected %h", o_rx_sop, e.sop));
	assert (o_rx_eop == e.eop)
		else report_fail($sformatf("Mismatch o_rx_eop: got %h expected %h", o_rx_eop, e.eop));
endtask

// done once every owed byte and drop has shown up
task automatic wait_outputs();
	while ((exp_q.size() != 0) || (drop_cnt != exp_drops)) begin
		@(posedge i_clk);
	end
	// catch late extra bytes or drops
	repeat (8) @(posedge i_clk);
endtask

// --------------------
// directed tests
// --------------------

task automatic test_good_frame();
	$display("test 1: good 64 byte frame");
	make_payload(60);
	append_fcs(32'h0);
	expect_frame();
	load_frame();
	drive_burst(0);
	wait_outputs();
endtask

task automatic test_bad_fcs();
	$display("test 2: one fcs bit flipped");
	make_payload(60);
	append_fcs(32'h0000_0100);
	exp_drops++;
	load_frame();
	drive_burst(0);
	wait_outputs();
endtask

task automatic test_no_sfd();
	$display("test 3: no sfd, then a broken preamble");
	tx_q.delete();
	repeat (16) begin
		tx_q.push_back(8'h55);
	end
	drive_burst(0);
	make_payload(20);
	load_frame();
	// one bad byte in the middle of the preamble
	tx_q[3] = 8'h54;
	drive_burst(0);
	wait_outputs();
endtask

task automatic test_back_to_back();
	$display("test 4: three frames at minimum gap, middle one bad");
	for (int f = 0; f < 3; f++) begin
		make_payload(60);
		if (f == 1) begin
			append_fcs(32'h8000_0000);
			exp_drops++;
		end else begin
			append_fcs(32'h0);
			expect_frame();
		end
		load_frame();
		drive_burst(0);
	end
	wait_outputs();
endtask

task automatic test_oversize();
	$display("test 5: oversize burst, then a good frame");
	// first MAX_BYTES carry a valid fcs, so only the length can drop it
	make_payload(MAX_BYTES - 4);
	append_fcs(32'h0);
	repeat (32) begin
		pl_q.push_back(8'($random(seed)));
	end
	exp_drops++;
	load_frame();
	drive_burst(0);
	make_payload(60);
	append_fcs(32'h0);
	expect_frame();
	load_frame();
	drive_burst(0);
	wait_outputs();
endtask

task automatic test_extra_dibit();
	$display("test 6: good frame plus one stray dibit");
	make_payload(60);
	append_fcs(32'h0);
	exp_drops++;
	load_frame();
	drive_burst(1);
	wait_outputs();
endtask

`endif

// File: bench/tb_mac_rx.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mac_rx;

	// --------------------
	// constants
	// --------------------

	localparam int CLK_PERIOD = 20;
	localparam int RST_CYCLES = 10;
	localparam integer SEED   = 32'ha03a;

	// small limit so the oversize burst stays short
	localparam int MAX_BYTES  = 128;
	localparam int FIFO_DEPTH = 2048;
	localparam int VQ_DEPTH   = 4;

	// 96 bit times of idle at two bits per cycle
	localparam int IFG_CYCLES = 48;

	// lsb-first form of 0x04c11db7
	localparam logic [31:0] CRC_POLY = 32'hedb8_8320;

	// preamble, sfd and 64 frame bytes
	localparam int FRAME_DIBITS = (8 + 64) * 4;

	// tests 1 and 2, test 3, test 4, test 5, test 6
	localparam int TEST_DIBITS = 2 * FRAME_DIBITS
		+ (16 + 8 + 20) * 4
		+ 3 * FRAME_DIBITS
		+ (8 + MAX_BYTES + 32) * 4 + FRAME_DIBITS
		+ FRAME_DIBITS + 1;
	localparam int TIMEOUT_CYCLES = RST_CYCLES + TEST_DIBITS + 6 * 200;

	// one expected output byte
	typedef struct packed {
		logic       sop;
		logic       eop;
		logic [7:0] data;
	} exp_byte_t;

	logic       i_clk;
	logic       i_rst_n;
	logic       i_rmii_rxvld;
	logic [1:0] i_rmii_rxdata;
	logic       o_rx_vld;
	logic       o_rx_sop;
	logic       o_rx_eop;
	logic [7:0] o_rx_dat;
	logic       o_frame_drop;

	integer     seed;
	int         cycle_cnt = 0;
	int         drop_cnt = 0;
	int         exp_drops;

	// payload plus fcs of the frame being built
	logic [7:0] pl_q[$];
	// bytes of the next burst on the wire
	logic [7:0] tx_q[$];
	// bytes still owed by the gate, in order
	exp_byte_t  exp_q[$];

	mac_rx_top #(
		.MAX_FRAME_BYTES (MAX_BYTES),
		.FIFO_DEPTH      (FIFO_DEPTH),
		.VERDICT_DEPTH   (VQ_DEPTH)
	) i_mac_rx_top (
		.i_clk         (i_clk),
		.i_rst_n       (i_rst_n),
		.i_rmii_rxvld  (i_rmii_rxvld),
		.i_rmii_rxdata (i_rmii_rxdata),
		.o_rx_vld      (o_rx_vld),
		.o_rx_sop      (o_rx_sop),
		.o_rx_eop      (o_rx_eop),
		.o_rx_dat      (o_rx_dat),
		.o_frame_drop  (o_frame_drop)
	);

	task automatic report_fail(input string msg);
		$display("%s", msg);
		$display("FAIL: see errors above");
		$fatal(1);
	endtask

	`include "tb_mac_rx_tasks.svh"

	// --------------------
	// clock and timeout
	// --------------------

	initial begin
		i_clk = 1'b0;
		forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
	end

	always @(posedge i_clk) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			report_fail($sformatf("timeout after %0d cycles, frames still pending",
				cycle_cnt));
		end
	end

	// outputs settle long before the falling edge
	always @(negedge i_clk) begin
		if (i_rst_n) begin
			assert (o_rx_vld || (!o_rx_sop && !o_rx_eop))
				else report_fail("sop or eop raised without o_rx_vld");
			if (o_rx_vld) begin
				check_rx_byte();
			end
			if (o_frame_drop) begin
				assert (drop_cnt < exp_drops)
					else report_fail("frame dropped that should have been delivered");
				drop_cnt++;
			end
		end
	end

	// --------------------
	// test sequence
	// --------------------

	initial begin
		seed          = SEED;
		exp_drops     = 0;
		i_rst_n       = 1'b0;
		i_rmii_rxvld  = 1'b0;
		i_rmii_rxdata = 2'b00;
		repeat (RST_CYCLES) @(posedge i_clk);
		#1;
		i_rst_n = 1'b1;
		@(negedge i_clk);
		assert (!o_rx_vld && !o_rx_sop && !o_rx_eop && !o_frame_drop)
			else report_fail("outputs not idle after reset");

		test_good_frame();
		test_bad_fcs();
		test_no_sfd();
		test_back_to_back();
		test_oversize();
		test_extra_dibit();

		if ((exp_q.size() == 0) && (drop_cnt == exp_drops)) begin
			$display("PASS: all tests");
			$finish;
		end else begin
			report_fail("frames or drops still outstanding at end of run");
		end
	end

endmodule

`default_nettype wire

// File: common/mac_rx_pkg.sv
`default_nettype none

package mac_rx_pkg;

	// --------------------
	// byte stream
	// --------------------

	// one received byte plus its frame markers
	typedef struct packed {
		// first byte after the sfd
		logic       sop;
		// last byte of the frame
		logic       eop;
		// frame error, only valid with eop
		logic       err;
		logic [7:0] data;
	} mac_byte_t;

	// fifo word width for the byte stream
	localparam int MAC_BYTE_W = $bits(mac_byte_t);

	// --------------------
	// ethernet constants
	// --------------------

	// 7x 0x55 then 0xd5, as seen in a right-shifting dibit register
	// with the newest dibit entering at the msb end
	localparam logic [63:0] PREAMBLE_SFD = 64'hd555_5555_5555_5555;

	// crc-32, lsb-first form of 0x04c11db7
	localparam logic [31:0] CRC32_POLY_REFL = 32'hedb8_8320;

	// start value
	localparam logic [31:0] CRC32_INIT = 32'hffff_ffff;

	// register value after data plus a good fcs, no final inversion
	localparam logic [31:0] CRC32_RESIDUE = 32'hdebb_20e3;

endpackage

`default_nettype wire

// File: design/sync_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
	parameter int WIDTH = 8,
	// power of two
	parameter int DEPTH = 16
) (
	input  wire              i_clk,
	input  wire              i_rst_n,
	input  wire              i_wr_en,
	input  wire  [WIDTH-1:0] i_wr_data,
	input  wire              i_rd_en,
	output logic [WIDTH-1:0] o_rd_data,
	output logic             o_empty,
	output logic             o_full
);

	localparam int AW = $clog2(DEPTH);

	logic [WIDTH-1:0] r_mem [DEPTH];

	// extra msb tells full from empty
	logic [AW:0]      r_wr_ptr;
	logic [AW:0]      r_rd_ptr;
	logic             w_wr_ok;
	logic             w_rd_ok;

	assign o_empty = (r_wr_ptr == r_rd_ptr);
	assign o_full  = (r_wr_ptr[AW] != r_rd_ptr[AW]) &&
	                 (r_wr_ptr[AW-1:0] == r_rd_ptr[AW-1:0]);

	assign w_wr_ok = i_wr_en && !o_full;
	assign w_rd_ok = i_rd_en && !o_empty;

	// --------------------
	// storage
	// --------------------

	always_ff @(posedge i_clk) begin
		if (w_wr_ok) begin
			r_mem[r_wr_ptr[AW-1:0]] <= i_wr_data;
		end
	end

	// data one cycle after the read
	always_ff @(posedge i_clk) begin
		if (w_rd_ok) begin
			o_rd_data <= r_mem[r_rd_ptr[AW-1:0]];
		end
	end

	// pointers
	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			r_wr_ptr <= '0;
			r_rd_ptr <= '0;
		end else begin
			if (w_wr_ok) begin
				r_wr_ptr <= r_wr_ptr + (AW + 1)'(1);
			end
			if (w_rd_ok) begin
				r_rd_ptr <= r_rd_ptr + (AW + 1)'(1);
			end
		end
	end

endmodule

`default_nettype wire

// File: mac_rx/mac_rx_crc32.sv
`timescale 1ns/1ps
`default_nettype none

module mac_rx_crc32
	import mac_rx_pkg::*;
(
	input  wire        i_clk,
	input  wire        i_rst_n,
	input  wire        i_byte_vld,
	input  wire        mac_byte_t i_byte,
	output logic       o_verdict_vld,
	output logic       o_crc_ok
);

	logic [31:0] r_crc;
	logic [31:0] w_crc_base;
	logic [31:0] w_crc_nxt;

	// bytewise update, lsb first
	function automatic logic [31:0] crc_byte(input logic [31:0] crc, input logic [7:0] dat);
		logic [31:0] c;
		c = crc ^ {24'd0, dat};
		for (int i = 0; i < 8; i++) begin
			if (c[0]) begin
				c = (c >> 1) ^ CRC32_POLY_REFL;
			end else begin
				c = c >> 1;
			end
		end
		return c;
	endfunction

	// sop restarts from the init value in the same step
	assign w_crc_base = i_byte.sop ? CRC32_INIT : r_crc;
	assign w_crc_nxt  = crc_byte(w_crc_base, i_byte.data);

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			r_crc <= CRC32_INIT;
		end else if (i_byte_vld) begin
			r_crc <= w_crc_nxt;
		end
	end

	// --------------------
	// verdict
	// --------------------

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			o_verdict_vld <= 1'b0;
			o_crc_ok      <= 1'b0;
		end else begin
			o_verdict_vld <= i_byte_vld && i_byte.eop;
			// fcs included, so a good frame lands on the residue
			if (i_byte_vld && i_byte.eop) begin
				o_crc_ok <= (w_crc_nxt == CRC32_RESIDUE);
			end
		end
	end

endmodule

`default_nettype wire

// File: mac_rx/mac_rx_deframer.sv
`timescale 1ns/1ps
`default_nettype none

module mac_rx_deframer
	import mac_rx_pkg::*;
#(
	parameter int MAX_FRAME_BYTES = 1518
) (
	input  wire        i_clk,
	input  wire        i_rst_n,
	input  wire        i_rmii_rxvld,
	input  wire  [1:0] i_rmii_rxdata,
	output logic       o_byte_vld,
	output mac_byte_t  o_byte
);

	localparam int BCNT_W = $clog2(MAX_FRAME_BYTES + 1);

	// preamble search
	logic [63:0]       r_pre;
	logic [63:0]       w_pre_nxt;
	logic              w_sfd_hit;

	// frame state
	logic              r_in_frame;
	logic              r_skip;
	logic              r_first;
	logic [1:0]        r_dcnt;
	logic [5:0]        r_acc;
	logic [BCNT_W-1:0] r_bcnt;

	// one byte held back for eop marking
	logic              r_hold_sop;
	logic [7:0]        r_hold_data;
	logic              r_hold_vld;

	logic              w_at_limit;
	logic              w_byte_done;
	logic              w_close_fall;
	logic              w_close_over;
	logic              w_emit;

	// --------------------
	// preamble and sfd
	// --------------------

	// newest dibit enters at the top, low pair first
	assign w_pre_nxt = {i_rmii_rxdata, r_pre[63:2]};
	assign w_sfd_hit = i_rmii_rxvld && !r_in_frame && !r_skip && (w_pre_nxt == PREAMBLE_SFD);

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			r_pre <= '0;
		end else if (!i_rmii_rxvld || w_sfd_hit) begin
			// restart the search on every burst and after a match
			r_pre <= '0;
		end else if (!r_in_frame && !r_skip) begin
			r_pre <= w_pre_nxt;
		end
	end

	// --------------------
	// byte packing
	// --------------------

	// byte count already at the limit, one more dibit means oversize
	assign w_at_limit   = (r_bcnt == BCNT_W'(MAX_FRAME_BYTES));
	assign w_byte_done  = r_in_frame && i_rmii_rxvld && !w_at_limit && (r_dcnt == 2'd3);
	assign w_close_fall = r_in_frame && !i_rmii_rxvld;
	assign w_close_over = r_in_frame && i_rmii_rxvld && w_at_limit;

	// held byte leaves when a newer one completes or the frame closes
	assign w_emit = r_hold_vld && (w_byte_done || w_close_fall || w_close_over);

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			r_in_frame <= 1'b0;
			r_skip     <= 1'b0;
			r_first    <= 1'b0;
			r_dcnt     <= 2'd0;
			r_bcnt     <= '0;
			r_hold_vld <= 1'b0;
		end else if (w_sfd_hit) begin
			r_in_frame <= 1'b1;
			r_first    <= 1'b1;
			r_dcnt     <= 2'd0;
			r_bcnt     <= '0;
			r_hold_vld <= 1'b0;
		end else if (w_close_fall) begin
			r_in_frame <= 1'b0;
			r_hold_vld <= 1'b0;
		end else if (w_close_over) begin
			// rest of the burst is ignored
			r_in_frame <= 1'b0;
			r_skip     <= 1'b1;
			r_hold_vld <= 1'b0;
		end else if (r_in_frame) begin
			r_dcnt <= r_dcnt + 2'd1;
			if (w_byte_done) begin
				r_bcnt     <= r_bcnt + BCNT_W'(1);
				r_first    <= 1'b0;
				r_hold_vld <= 1'b1;
			end
		end else if (!i_rmii_rxvld) begin
			r_skip <= 1'b0;
		end
	end

	// dibits 0..2 of the current byte
	always_ff @(posedge i_clk) begin
		if (r_in_frame && i_rmii_rxvld) begin
			r_acc <= {i_rmii_rxdata, r_acc[5:2]};
		end
	end

	always_ff @(posedge i_clk) begin
		if (w_byte_done) begin
			r_hold_sop  <= r_first;
			r_hold_data <= {i_rmii_rxdata, r_acc};
		end
	end

	// --------------------
	// output
	// --------------------

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			o_byte_vld <= 1'b0;
		end else begin
			o_byte_vld <= w_emit;
		end
	end

	always_ff @(posedge i_clk) begin
		if (w_emit) begin
			o_byte.sop  <= r_hold_sop;
			o_byte.data <= r_hold_data;
			o_byte.eop  <= w_close_fall || w_close_over;
			// leftover dibits at the fall, or too long
			o_byte.err  <= w_close_over || (w_close_fall && (r_dcnt != 2'd0));
		end
	end

endmodule

`default_nettype wire

// File: mac_rx/mac_rx_frame_gate.sv
`timescale 1ns/1ps
`default_nettype none

module mac_rx_frame_gate
	import mac_rx_pkg::*;
#(
	// power of two
	parameter int VERDICT_DEPTH = 4
) (
	input  wire        i_clk,
	input  wire        i_rst_n,
	input  wire        i_byte_vld,
	input  wire        i_frame_err,
	input  wire        i_verdict_vld,
	input  wire        i_crc_ok,
	input  wire        mac_byte_t i_fifo_data,
	input  wire        i_fifo_empty,
	output logic       o_fifo_rd,
	output logic       o_rx_vld,
	output logic       o_rx_sop,
	output logic       o_rx_eop,
	output logic [7:0] o_rx_dat,
	output logic       o_frame_drop
);

	localparam int QW = $clog2(VERDICT_DEPTH);

	typedef enum logic {
		ST_IDLE,
		ST_DRAIN
	} gate_state_t;

	gate_state_t r_state;

	// keep bits in frame order
	logic [VERDICT_DEPTH-1:0] r_vq;
	logic [QW-1:0]            r_vq_wr;
	logic [QW-1:0]            r_vq_rd;
	logic [QW:0]              r_vq_cnt;

	logic                     r_frame_err;
	logic                     r_keep;
	logic                     r_rd_d;
	logic                     w_start;
	logic                     w_eop_seen;

	// --------------------
	// verdict queue
	// --------------------

	// err only ever set on the eop byte, verdict follows one cycle later
	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			r_frame_err <= 1'b0;
		end else if (i_byte_vld) begin
			r_frame_err <= i_frame_err;
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_verdict_vld) begin
			r_vq[r_vq_wr] <= i_crc_ok && !r_frame_err;
		end
	end

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			r_vq_wr  <= '0;
			r_vq_rd  <= '0;
			r_vq_cnt <= '0;
		end else begin
			if (i_verdict_vld) begin
				r_vq_wr <= r_vq_wr + QW'(1);
			end
			if (w_start) begin
				r_vq_rd <= r_vq_rd + QW'(1);
			end
			r_vq_cnt <= r_vq_cnt + (QW + 1)'(i_verdict_vld) - (QW + 1)'(w_start);
		end
	end

	// --------------------
	// drain fsm
	// --------------------

	// whole frame is in the fifo once its verdict is queued
	assign w_start    = (r_state == ST_IDLE) && (r_vq_cnt != '0) && !i_fifo_empty;
	assign w_eop_seen = r_rd_d && i_fifo_data.eop;

	// stop reading as soon as the eop entry shows up
	always_comb begin
		o_fifo_rd = 1'b0;
		if (w_start) begin
			o_fifo_rd = 1'b1;
		end else if (r_state == ST_DRAIN) begin
			o_fifo_rd = !i_fifo_empty && !w_eop_seen;
		end
	end

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			r_state <= ST_IDLE;
			r_keep  <= 1'b0;
			r_rd_d  <= 1'b0;
		end else begin
			r_rd_d <= o_fifo_rd;
			if (w_start) begin
				r_state <= ST_DRAIN;
				r_keep  <= r_vq[r_vq_rd];
			end else if ((r_state == ST_DRAIN) && w_eop_seen) begin
				r_state <= ST_IDLE;
			end
		end
	end

	// --------------------
	// output
	// --------------------

	// two cycles after the read
	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			o_rx_vld     <= 1'b0;
			o_rx_sop     <= 1'b0;
			o_rx_eop     <= 1'b0;
			o_frame_drop <= 1'b0;
		end else begin
			o_rx_vld     <= r_rd_d && r_keep;
			o_rx_sop     <= r_rd_d && r_keep && i_fifo_data.sop;
			o_rx_eop     <= r_rd_d && r_keep && i_fifo_data.eop;
			o_frame_drop <= r_rd_d && !r_keep && i_fifo_data.eop;
		end
	end

	always_ff @(posedge i_clk) begin
		if (r_rd_d) begin
			o_rx_dat <= i_fifo_data.data;
		end
	end

endmodule

`default_nettype wire

// File: mac_rx/mac_rx_top.sv
`timescale 1ns/1ps
`default_nettype none

module mac_rx_top
	import mac_rx_pkg::*;
#(
	parameter int MAX_FRAME_BYTES = 1518,
	parameter int FIFO_DEPTH      = 2048,
	parameter int VERDICT_DEPTH   = 4
) (
	input  wire        i_clk,
	input  wire        i_rst_n,
	input  wire        i_rmii_rxvld,
	input  wire  [1:0] i_rmii_rxdata,
	output logic       o_rx_vld,
	output logic       o_rx_sop,
	output logic       o_rx_eop,
	output logic [7:0] o_rx_dat,
	output logic       o_frame_drop
);

	// deframer byte stream, fans out to crc and fifo
	logic      w_byte_vld;
	mac_byte_t w_byte;

	logic      w_verdict_vld;
	logic      w_crc_ok;

	logic      w_fifo_rd;
	mac_byte_t w_fifo_data;
	logic      w_fifo_empty;

	mac_rx_deframer #(
		.MAX_FRAME_BYTES (MAX_FRAME_BYTES)
	) u_deframer (
		.i_clk         (i_clk),
		.i_rst_n       (i_rst_n),
		.i_rmii_rxvld  (i_rmii_rxvld),
		.i_rmii_rxdata (i_rmii_rxdata),
		.o_byte_vld    (w_byte_vld),
		.o_byte        (w_byte)
	);

	mac_rx_crc32 u_crc32 (
		.i_clk         (i_clk),
		.i_rst_n       (i_rst_n),
		.i_byte_vld    (w_byte_vld),
		.i_byte        (w_byte),
		.o_verdict_vld (w_verdict_vld),
		.o_crc_ok      (w_crc_ok)
	);

	// drained at one byte per cycle, filled at most one per four,
	// so full never rises
	sync_fifo #(
		.WIDTH (MAC_BYTE_W),
		.DEPTH (FIFO_DEPTH)
	) u_frame_fifo (
		.i_clk     (i_clk),
		.i_rst_n   (i_rst_n),
		.i_wr_en   (w_byte_vld),
		.i_wr_data (w_byte),
		.i_rd_en   (w_fifo_rd),
		.o_rd_data (w_fifo_data),
		.o_empty   (w_fifo_empty),
		.o_full    ()
	);

	mac_rx_frame_gate #(
		.VERDICT_DEPTH (VERDICT_DEPTH)
	) u_frame_gate (
		.i_clk         (i_clk),
		.i_rst_n       (i_rst_n),
		.i_byte_vld    (w_byte_vld),
		.i_frame_err   (w_byte.err),
		.i_verdict_vld (w_verdict_vld),
		.i_crc_ok      (w_crc_ok),
		.i_fifo_data   (w_fifo_data),
		.i_fifo_empty  (w_fifo_empty),
		.o_fifo_rd     (w_fifo_rd),
		.o_rx_vld      (o_rx_vld),
		.o_rx_sop      (o_rx_sop),
		.o_rx_eop      (o_rx_eop),
		.o_rx_dat      (o_rx_dat),
		.o_frame_drop  (o_frame_drop)
	);

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# build and run the RMII receive testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 -f vlog.f --top-module tb_mac_rx -o sim_tb_mac_rx

# the simulator exits nonzero on a fatal error, the search below decides
out=$(./obj_dir/sim_tb_mac_rx 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -q "PASS: all tests"; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed"
	exit 1
fi

// File: vlog.f
common/mac_rx_pkg.sv
design/sync_fifo.sv
mac_rx/mac_rx_deframer.sv
mac_rx/mac_rx_crc32.sv
mac_rx/mac_rx_frame_gate.sv
mac_rx/mac_rx_top.sv
+incdir+bench
bench/tb_mac_rx.sv
